//--- logic/mtag_apb_port.sv
// APB slave that lets software read and write tag entries through the shared tag-memory bus.
`timescale 1ns/1ps
`include "mtag_cfg.svh"

module mtag_apb_port (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [`MTAG_APB_AW-1:0]       paddr_i,
    input  logic [`MTAG_XLEN-1:0]         pwdata_i,
    output logic [`MTAG_XLEN-1:0]         prdata_o,
    output logic                          pready_o,
    output logic                          tmem_cyc_o,
    output logic                          tmem_stb_o,
    output logic                          tmem_we_o,
    output logic [`MTAG_TADR_WIDTH-1:0]   tmem_adr_o,
    output mtag_types_pkg::tag_word_u     tmem_wdat_o,
    input  mtag_types_pkg::tag_word_u     tmem_dat_i,
    input  logic                          tmem_ack_i
);
    import mtag_types_pkg::*;

    // FSM encoding.
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_bus  = 2'd1;
    localparam logic [1:0] st_done = 2'd2;

    logic [1:0] state_q;
    tag_word_u  rdat_q;
    logic       setup;

    // the setup phase is the one cycle with psel high and penable still low.
    assign setup = psel_i && !penable_i;

    // registers sit on a word grid, so the two lowest address bits are ignored.
    // the master holds paddr, pwrite and pwdata for the whole access phase.
    assign tmem_adr_o  = paddr_i[2 +: `MTAG_TADR_WIDTH];
    assign tmem_we_o   = pwrite_i;
    assign tmem_wdat_o = tag_word_u'(pwdata_i[`MTAG_TLEN-1:0]);

    assign tmem_cyc_o = (state_q == st_bus);
    assign tmem_stb_o = (state_q == st_bus);

    // pready rises in the cycle after the tag-memory ack.
    assign pready_o = (state_q == st_done);

    // entries are narrower than the APB bus, the upper bits read as zero.
    assign prdata_o = {{(`MTAG_XLEN-`MTAG_TLEN){1'b0}}, rdat_q.raw};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    if (setup) begin
                        state_q <= st_bus;
                    end
                end
                st_bus: begin
                    if (tmem_ack_i) begin
                        state_q <= st_done;
                    end
                end
                st_done: begin
                    // the access phase ends at this edge because pready is high.
                    if (psel_i && penable_i) begin
                        state_q <= st_idle;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // read data is captured once, while the RAM presents it with ack.
    always_ff @(posedge clk_i) begin
        if ((state_q == st_bus) && tmem_ack_i && !pwrite_i) begin
            rdat_q <= tmem_dat_i;
        end
    end

    // an APB master may only enable a selected slave.
    a_penable_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        penable_i |-> psel_i);

    // pready is only answered inside an access phase that this port started.
    a_ready_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pready_o |-> psel_i && penable_i);

endmodule

//--- logic/mtag_bus_pkg.sv
// Master numbering and grant type of the shared tag-memory bus, used by the arbiter and the top level.
`include "mtag_cfg.svh"

package mtag_bus_pkg;

    // index of a bus master.
    // hart h is master h, so the checkers need no constant of their own.
    typedef logic [$clog2(`MTAG_REQS)-1:0] req_idx_t;

    // one-hot grant, one bit per master.
    // all zero means the bus is idle.
    typedef logic [`MTAG_REQS-1:0] grant_t;

    // the APB port takes the slot right after the last hart.
    // it is therefore also the lowest priority after reset.
    localparam req_idx_t req_apb = req_idx_t'(`MTAG_HARTS);

endpackage

//--- logic/mtag_cfg.svh
// Compile-time widths and sizes of the tag-checking unit, included by every RTL file and the testbench.
`ifndef MTAG_CFG_SVH
`define MTAG_CFG_SVH

// pointer width of the core, also the APB data width.
`define MTAG_XLEN 32

// width of one tag-memory entry.
`define MTAG_TLEN 16

// number of harts, which is also the width of the ownership mask.
`define MTAG_HARTS 2

// size of one tagged granule in bytes.
`define MTAG_GRANULARITY 8

// physical address bits that take part in the granule lookup.
`define MTAG_ADR_WIDTH 8

// tag-memory index width, giving 32 entries.
`define MTAG_TADR_WIDTH 5

// address width of the software APB port.
`define MTAG_APB_AW 8

// number of masters on the shared tag-memory bus, two harts plus APB.
`define MTAG_REQS 3

`endif

//--- logic/mtag_chk.sv
// Per-hart tag checker that fetches the granule's entry and reports colour or ownership faults.
`timescale 1ns/1ps
`include "mtag_cfg.svh"

module mtag_chk #(
    parameter int HART_ID = 0
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          ena_i,
    input  logic [`MTAG_XLEN-1:0]         adr_i,
    output logic                          done_o,
    output logic                          err_o,
    output logic                          tmem_cyc_o,
    output logic                          tmem_stb_o,
    output logic [`MTAG_TADR_WIDTH-1:0]   tmem_adr_o,
    input  mtag_types_pkg::tag_word_u     tmem_dat_i,
    input  logic                          tmem_ack_i
);
    import mtag_types_pkg::*;

    // low address bits that select a byte inside one granule.
    localparam int gran_lsb = $clog2(`MTAG_GRANULARITY);
    localparam int colour_w = `MTAG_TLEN - `MTAG_HARTS;

    // FSM encoding.
    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_req    = 2'd1;
    localparam logic [1:0] st_report = 2'd2;

    logic [1:0]  state_q;
    logic        err_q;
    tag_colour_t ptr_colour;
    logic        violation;

    // the pointer carries its colour in the topmost bits.
    assign ptr_colour = adr_i[`MTAG_XLEN-1 -: colour_w];

    // the entry index is simply the granule number inside the checked window.
    assign tmem_adr_o = adr_i[`MTAG_ADR_WIDTH-1:gran_lsb];

    // a fault is either a cleared ownership bit or a colour mismatch.
    // both are evaluated on the fields view of the returned entry.
    assign violation = !tmem_dat_i.fields.mask[HART_ID]
                    || (tmem_dat_i.fields.colour != ptr_colour);

    // cycle and strobe stay up from the request until the ack edge.
    // the arbiter therefore keeps this hart's grant through the whole transfer.
    assign tmem_cyc_o = (state_q == st_req);
    assign tmem_stb_o = (state_q == st_req);

    // the report state lasts one cycle, which makes done a registered pulse.
    assign done_o = (state_q == st_report);
    assign err_o  = err_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= st_idle;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (ena_i) begin
                        state_q <= st_req;
                    end
                end
                st_req: begin
                    // read data is only valid while ack is high.
                    if (tmem_ack_i) begin
                        state_q <= st_report;
                        err_q   <= violation;
                    end
                end
                st_report: begin
                    // the hart drops ena_i after done, so no new request starts here.
                    state_q <= st_idle;
                    err_q   <= 1'b0;
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // an ack from the shared bus may only answer a cycle and strobe that this hart holds open.
    a_ack_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        tmem_ack_i |-> tmem_cyc_o && tmem_stb_o);

    // the hart must keep the pointer steady while the entry is being fetched.
    a_adr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q == st_req) && $past(state_q == st_req) |-> $stable(adr_i));

endmodule

//--- logic/mtag_types_pkg.sv
// Tag-entry types shared by the checkers, the APB port, the arbiter and the tag RAM.
`include "mtag_cfg.svh"

package mtag_types_pkg;

    // the colour fills every entry bit above the ownership mask.
    // it is compared against the top bits of a tagged pointer.
    typedef logic [`MTAG_TLEN-`MTAG_HARTS-1:0] tag_colour_t;

    // one bit per hart.
    // a set bit means that hart may touch the granule.
    typedef logic [`MTAG_HARTS-1:0] hart_mask_t;

    // decoded view of an entry, colour in the high bits and mask in the low bits.
    typedef struct packed {
        tag_colour_t colour;
        hart_mask_t  mask;
    } tag_fields_t;

    // a tag entry is stored and moved as a raw word.
    // the checkers look at the same bits through the fields view.
    typedef union packed {
        logic [`MTAG_TLEN-1:0] raw;
        tag_fields_t           fields;
    } tag_word_u;

endpackage

//--- logic/mtag_unit_top.sv
// Top level of the tag-checking unit that joins the hart checkers, the APB port, the arbiter and the RAM.
`timescale 1ns/1ps
`include "mtag_cfg.svh"

module mtag_unit_top (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [`MTAG_HARTS-1:0]    chk_ena_i,
    input  logic [`MTAG_XLEN-1:0]     chk_adr_i [`MTAG_HARTS],
    output logic [`MTAG_HARTS-1:0]    chk_done_o,
    output logic [`MTAG_HARTS-1:0]    chk_err_o,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [`MTAG_APB_AW-1:0]   paddr_i,
    input  logic [`MTAG_XLEN-1:0]     pwdata_i,
    output logic [`MTAG_XLEN-1:0]     prdata_o,
    output logic                      pready_o
);
    import mtag_types_pkg::*;
    import mtag_bus_pkg::*;

    // master side of the shared bus, indexed by master number.
    logic [`MTAG_REQS-1:0]         req_cyc;
    logic [`MTAG_REQS-1:0]         req_stb;
    logic [`MTAG_REQS-1:0]         req_we;
    logic [`MTAG_REQS-1:0]         req_ack;
    logic [`MTAG_TADR_WIDTH-1:0]   req_adr [`MTAG_REQS];
    tag_word_u                     req_wdat [`MTAG_REQS];
    tag_word_u                     bus_rdat;

    // RAM side of the shared bus.
    logic                          mem_stb;
    logic                          mem_we;
    logic [`MTAG_TADR_WIDTH-1:0]   mem_adr;
    tag_word_u                     mem_wdat;
    tag_word_u                     mem_dat;
    logic                          mem_ack;

    // hart h uses bus master slot h.
    // checkers only read, so their write lines are tied off.
    for (genvar h = 0; h < `MTAG_HARTS; h++) begin : g_chk
        assign req_we[h]   = 1'b0;
        assign req_wdat[h] = '0;

        mtag_chk #(
            .HART_ID (h)
        ) i_mtag_chk (
            .clk_i      (clk_i),
            .rst_n_i    (rst_n_i),
            .ena_i      (chk_ena_i[h]),
            .adr_i      (chk_adr_i[h]),
            .done_o     (chk_done_o[h]),
            .err_o      (chk_err_o[h]),
            .tmem_cyc_o (req_cyc[h]),
            .tmem_stb_o (req_stb[h]),
            .tmem_adr_o (req_adr[h]),
            .tmem_dat_i (bus_rdat),
            .tmem_ack_i (req_ack[h])
        );
    end

    mtag_apb_port i_mtag_apb_port (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .tmem_cyc_o  (req_cyc[req_apb]),
        .tmem_stb_o  (req_stb[req_apb]),
        .tmem_we_o   (req_we[req_apb]),
        .tmem_adr_o  (req_adr[req_apb]),
        .tmem_wdat_o (req_wdat[req_apb]),
        .tmem_dat_i  (bus_rdat),
        .tmem_ack_i  (req_ack[req_apb])
    );

    tmem_arbiter i_tmem_arbiter (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .cyc_i      (req_cyc),
        .stb_i      (req_stb),
        .we_i       (req_we),
        .adr_i      (req_adr),
        .wdat_i     (req_wdat),
        .ack_o      (req_ack),
        .rdat_o     (bus_rdat),
        .mem_stb_o  (mem_stb),
        .mem_we_o   (mem_we),
        .mem_adr_o  (mem_adr),
        .mem_wdat_o (mem_wdat),
        .mem_dat_i  (mem_dat),
        .mem_ack_i  (mem_ack)
    );

    tag_mem i_tag_mem (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .stb_i   (mem_stb),
        .we_i    (mem_we),
        .adr_i   (mem_adr),
        .wdat_i  (mem_wdat),
        .dat_o   (mem_dat),
        .ack_o   (mem_ack)
    );

endmodule

//--- logic/tag_mem.sv
// Tag RAM with one entry per granule, served through a single cyc/stb/ack port.
`timescale 1ns/1ps
`include "mtag_cfg.svh"

module tag_mem (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          stb_i,
    input  logic                          we_i,
    input  logic [`MTAG_TADR_WIDTH-1:0]   adr_i,
    input  mtag_types_pkg::tag_word_u     wdat_i,
    output mtag_types_pkg::tag_word_u     dat_o,
    output logic                          ack_o
);
    import mtag_types_pkg::*;

    localparam int depth = 2 ** `MTAG_TADR_WIDTH;

    tag_word_u mem_q [depth];
    tag_word_u dat_q;
    logic      ack_q;
    logic      access;

    // a strobe is served once, the ack cycle itself starts nothing new.
    // the master drops its strobe right after the ack.
    assign access = stb_i && !ack_q;

    // entries come out of reset as zero, so no hart owns any granule yet.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            for (int i = 0; i < depth; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            ack_q <= access;
            if (access && we_i) begin
                mem_q[adr_i] <= wdat_i;
            end
        end
    end

    // registered read, valid in the ack cycle.
    always_ff @(posedge clk_i) begin
        if (access) begin
            dat_q <= mem_q[adr_i];
        end
    end

    assign dat_o = dat_q;
    assign ack_o = ack_q;

endmodule

//--- logic/tmem_arbiter.sv
// Round-robin arbiter that hands the single tag-memory port to one bus master at a time.
`timescale 1ns/1ps
`include "mtag_cfg.svh"

module tmem_arbiter (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic [`MTAG_REQS-1:0]         cyc_i,
    input  logic [`MTAG_REQS-1:0]         stb_i,
    input  logic [`MTAG_REQS-1:0]         we_i,
    input  logic [`MTAG_TADR_WIDTH-1:0]   adr_i [`MTAG_REQS],
    input  mtag_types_pkg::tag_word_u     wdat_i [`MTAG_REQS],
    output logic [`MTAG_REQS-1:0]         ack_o,
    output mtag_types_pkg::tag_word_u     rdat_o,
    output logic                          mem_stb_o,
    output logic                          mem_we_o,
    output logic [`MTAG_TADR_WIDTH-1:0]   mem_adr_o,
    output mtag_types_pkg::tag_word_u     mem_wdat_o,
    input  mtag_types_pkg::tag_word_u     mem_dat_i,
    input  logic                          mem_ack_i
);
    import mtag_types_pkg::*;
    import mtag_bus_pkg::*;

    grant_t   grant_q;
    grant_t   grant_nxt;
    grant_t   grant;
    req_idx_t last_q;
    req_idx_t win_nxt;
    logic     busy;

    // the bus stays with the current owner for as long as its cycle is open.
    // the owner drops cyc right after its ack, which frees the bus that cycle.
    assign busy  = |(grant_q & cyc_i);
    assign grant = busy ? grant_q : grant_nxt;

    // search the masters in order, starting just after the last winner.
    always_comb begin
        int cand;
        grant_nxt = '0;
        win_nxt   = last_q;
        for (int i = 1; i <= `MTAG_REQS; i++) begin
            cand = (int'(last_q) + i) % `MTAG_REQS;
            if ((grant_nxt == '0) && cyc_i[cand]) begin
                grant_nxt[cand] = 1'b1;
                win_nxt         = req_idx_t'(cand);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            grant_q <= '0;
            // hart 0 wins the first contest after reset.
            last_q  <= req_apb;
        end else begin
            grant_q <= grant;
            if (!busy && (grant_nxt != '0)) begin
                last_q <= win_nxt;
            end
        end
    end

    // the grant is one-hot, so an OR of the masked requests selects the owner.
    assign mem_stb_o = |(grant & stb_i);
    assign mem_we_o  = |(grant & we_i);

    always_comb begin
        mem_adr_o  = '0;
        mem_wdat_o = '0;
        for (int r = 0; r < `MTAG_REQS; r++) begin
            if (grant[r]) begin
                mem_adr_o  = adr_i[r];
                mem_wdat_o = wdat_i[r];
            end
        end
    end

    // ack goes back to the owner only, read data may be shared by all.
    assign ack_o  = grant & {`MTAG_REQS{mem_ack_i}};
    assign rdat_o = mem_dat_i;

    a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(grant));

    // every ack must reach the master whose strobe the RAM saw one cycle before.
    a_ack_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_ack_i |-> ack_o == $past(grant & stb_i));

endmodule

//--- run.sh
#!/bin/sh
# Builds the tag-checking unit testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module mtag_unit_tb -f src.f -o mtag_unit_sim

# the simulator status is not trusted, the log decides.
./obj_dir/mtag_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

//--- src.f
+incdir+logic
logic/mtag_types_pkg.sv
logic/mtag_bus_pkg.sv
logic/mtag_chk.sv
logic/mtag_apb_port.sv
logic/tmem_arbiter.sv
logic/tag_mem.sv
logic/mtag_unit_top.sv
verification/mtag_unit_tb.sv

//--- verification/mtag_unit_tb.sv
// Self-checking testbench of the tag-checking unit; the Verilator script builds it from src.f.
`timescale 1ns/1ps
`include "mtag_cfg.svh"

module mtag_unit_tb;
    import mtag_types_pkg::*;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 16;
    // three cycles alone on the bus, plus two foreign transfers of two cycles each.
    localparam int lat_min = 3;
    localparam int lat_max = 7;
    // 4 reset reads, 12 APB round trips, 12 for the hart checks, 4 contention rounds of 5.
    localparam int n_trans = 48;

    logic                          clk_i;
    logic                          rst_n_i;
    logic [`MTAG_HARTS-1:0]        chk_ena_i;
    logic [`MTAG_XLEN-1:0]         chk_adr_i [`MTAG_HARTS];
    logic [`MTAG_HARTS-1:0]        chk_done_o;
    logic [`MTAG_HARTS-1:0]        chk_err_o;
    logic                          psel_i;
    logic                          penable_i;
    logic                          pwrite_i;
    logic [`MTAG_APB_AW-1:0]       paddr_i;
    logic [`MTAG_XLEN-1:0]         pwdata_i;
    logic [`MTAG_XLEN-1:0]         prdata_o;
    logic                          pready_o;

    // reference copy of every entry that software has written.
    tag_word_u              model [2 ** `MTAG_TADR_WIDTH];
    logic [15:0]            lfsr_q = 16'd68;
    logic [`MTAG_HARTS-1:0] exp_err;
    logic [`MTAG_TLEN-1:0]  exp_rdata;
    logic                   quiet;
    int                     lat_cnt [`MTAG_HARTS];
    int                     apb_cnt;
    int                     errors;

    mtag_unit_top i_mtag_unit_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #(clk_period / 2) clk_i = ~clk_i;
    end

    // one Galois step of a 16-bit maximal-length LFSR.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // collects n random bits, one LFSR step per bit.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    // a tagged pointer carries its colour on top and the granule number in bits 7 to 3.
    function automatic logic [`MTAG_XLEN-1:0] make_ptr(input tag_colour_t colour,
                                                      input logic [4:0] idx);
        logic [31:0] mid;
        logic [31:0] low;
        mid = take_bits(10);
        low = take_bits(3);
        return {colour, mid[9:0], idx, low[2:0]};
    endfunction

    // a fault is a cleared ownership bit or a colour that differs from the pointer's.
    function automatic logic expect_violation(input int h, input logic [`MTAG_XLEN-1:0] adr);
        tag_word_u e;
        e = model[adr[7:3]];
        return !e.fields.mask[h] || (e.fields.colour != adr[31:18]);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
        $display("FAIL: see errors above");
        $fatal(1, "value check failed");
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("at %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "protocol check failed");
    endtask

    // one APB transfer, held in the access phase until pready.
    task automatic apb_access(input logic wr, input logic [4:0] idx,
                              input logic [`MTAG_TLEN-1:0] data);
        logic [31:0] junk;
        junk = take_bits(16);
        @(posedge clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= wr;
        paddr_i   <= {1'b0, idx, 2'b00};
        pwdata_i  <= {junk[15:0], data};
        @(posedge clk_i);
        penable_i <= 1'b1;
        do @(negedge clk_i); while (!pready_o);
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic write_entry(input logic [4:0] idx, input tag_colour_t colour,
                               input hart_mask_t mask);
        tag_word_u w;
        w.fields.colour = colour;
        w.fields.mask   = mask;
        model[idx] = w;
        apb_access(1'b1, idx, w.raw);
    endtask

    task automatic read_entry(input logic [4:0] idx);
        exp_rdata = model[idx].raw;
        apb_access(1'b0, idx, '0);
    endtask

    // the hart holds enable and pointer until done, then releases enable.
    task automatic run_check(input int h, input logic [`MTAG_XLEN-1:0] adr);
        exp_err[h] = expect_violation(h, adr);
        @(posedge clk_i);
        chk_ena_i[h] <= 1'b1;
        chk_adr_i[h] <= adr;
        do @(negedge clk_i); while (!chk_done_o[h]);
        @(posedge clk_i);
        chk_ena_i[h] <= 1'b0;
    endtask

    // cycles since each request was raised, used for the latency bounds.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int h = 0; h < `MTAG_HARTS; h++) begin
                lat_cnt[h] <= 0;
            end
            apb_cnt <= 0;
        end else begin
            for (int h = 0; h < `MTAG_HARTS; h++) begin
                lat_cnt[h] <= chk_ena_i[h] ? lat_cnt[h] + 1 : 0;
            end
            apb_cnt <= psel_i ? apb_cnt + 1 : 0;
        end
    end

    a_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        quiet |-> (chk_done_o == '0) && (chk_err_o == '0) && !pready_o)
        else report_mismatch("{chk_done_o, chk_err_o, pready_o}", '0,
            32'({$sampled(chk_done_o), $sampled(chk_err_o), $sampled(pready_o)}));

    a_prdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pready_o && !pwrite_i |-> prdata_o == {16'h0, exp_rdata})
        else report_mismatch("prdata_o", {16'h0, exp_rdata}, $sampled(prdata_o));

    // pready stays low for the first two access cycles.
    a_pready_lat: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pready_o |-> (apb_cnt >= lat_min) && (apb_cnt <= lat_max))
        else report_failure($sformatf("pready_o came %0d cycles after setup",
            $sampled(apb_cnt)));

    a_apb_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        psel_i |-> apb_cnt <= lat_max)
        else report_failure("APB access waited longer than round-robin allows");

    for (genvar h = 0; h < `MTAG_HARTS; h++) begin : g_hart
        a_err_value: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            chk_done_o[h] |-> chk_err_o[h] == exp_err[h])
            else report_mismatch($sformatf("chk_err_o[%0d]", h), 32'(exp_err[h]),
                32'($sampled(chk_err_o[h])));

        a_err_with_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            chk_err_o[h] |-> chk_done_o[h])
            else report_failure($sformatf("chk_err_o[%0d] high without done", h));

        a_done_lat: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            chk_done_o[h] |-> chk_ena_i[h] && (lat_cnt[h] >= lat_min)
                && (lat_cnt[h] <= lat_max))
            else report_failure($sformatf("chk_done_o[%0d] outside a request window", h));

        a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            chk_done_o[h] |=> !chk_done_o[h])
            else report_failure($sformatf("chk_done_o[%0d] longer than one cycle", h));

        a_hart_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            chk_ena_i[h] |-> lat_cnt[h] <= lat_max)
            else report_failure($sformatf("hart %0d waited too long for the bus", h));
    end

    initial begin
        repeat (reset_cycles + n_trans * 200) @(posedge clk_i);
        $display("watchdog expired: the tests did not finish in time");
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

    initial begin
        logic [4:0]            idx;
        logic [4:0]            idx1;
        logic [4:0]            idx2;
        tag_colour_t           colour;
        hart_mask_t            mask;
        logic [`MTAG_XLEN-1:0] ptr0;
        logic [`MTAG_XLEN-1:0] ptr1;
        rst_n_i   = 1'b0;
        chk_ena_i = '0;
        chk_adr_i[0] = '0;
        chk_adr_i[1] = '0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        errors    = 0;
        quiet     = 1'b1;
        exp_err   = '0;
        exp_rdata = '0;
        foreach (model[i]) model[i] = '0;
        repeat (reset_cycles) @(posedge clk_i);
        rst_n_i <= 1'b1;
        repeat (4) @(posedge clk_i);
        quiet = 1'b0;

        // entries come out of reset cleared.
        repeat (4) read_entry(5'(take_bits(5)));

        // software round trips through the APB port.
        repeat (6) begin
            idx = 5'(take_bits(5));
            write_entry(idx, tag_colour_t'(take_bits(14)), hart_mask_t'(take_bits(2)));
            read_entry(idx);
        end

        // match, then an ownership fault, then a colour fault on each hart.
        for (int h = 0; h < `MTAG_HARTS; h++) begin
            idx = 5'(take_bits(5));
            colour = tag_colour_t'(take_bits(14));
            mask = hart_mask_t'(take_bits(2));
            mask[h] = 1'b1;
            write_entry(idx, colour, mask);
            run_check(h, make_ptr(colour, idx));
            mask[h] = 1'b0;
            write_entry(idx, colour, mask);
            run_check(h, make_ptr(colour, idx));
            mask[h] = 1'b1;
            write_entry(idx, colour, mask);
            run_check(h, make_ptr(colour ^ (tag_colour_t'(take_bits(14)) | 14'd1), idx));
        end

        // both harts and a software read hit the bus in the same cycle.
        repeat (4) begin
            idx  = 5'(take_bits(5));
            idx1 = 5'(take_bits(5));
            idx2 = 5'(take_bits(5));
            write_entry(idx, tag_colour_t'(take_bits(14)), hart_mask_t'(take_bits(2)));
            write_entry(idx1, tag_colour_t'(take_bits(14)), hart_mask_t'(take_bits(2)));
            // about half of the pointers reuse the stored colour.
            colour = take_bits(1) ? model[idx].fields.colour : tag_colour_t'(take_bits(14));
            ptr0 = make_ptr(colour, idx);
            colour = take_bits(1) ? model[idx1].fields.colour : tag_colour_t'(take_bits(14));
            ptr1 = make_ptr(colour, idx1);
            fork
                run_check(0, ptr0);
                run_check(1, ptr1);
                read_entry(idx2);
            join
        end

        repeat (4) @(posedge clk_i);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
